//--- Bender.yml
package:
  name: fixed_self_attention_head

sources:
  - files:
      - verilog/attention_pkg.sv
      - verilog/row_matrix_buffer.sv
      - verilog/query_key_scores.sv
      - verilog/shift_softermax.sv
      - verilog/weighted_value_sum.sv
      - verilog/output_round_slice.sv
      - verilog/fixed_self_attention_head.sv
  - target: test
    files:
      - testbench/attention_head_checker.sv
      - testbench/attention_head_monitor.sv
      - testbench/attention_head_tb.sv

//--- all.f
verilog/attention_pkg.sv
verilog/row_matrix_buffer.sv
verilog/query_key_scores.sv
verilog/shift_softermax.sv
verilog/weighted_value_sum.sv
verilog/output_round_slice.sv
verilog/fixed_self_attention_head.sv
testbench/attention_head_checker.sv
testbench/attention_head_monitor.sv
testbench/attention_head_tb.sv

//--- testbench/attention_head_checker.sv
`default_nettype none

module attention_head_checker import attention_pkg::*; #(
  parameter int SEQ_LEN = DEFAULT_SEQ_LEN,
  parameter int EMBED_DIM = DEFAULT_EMBED_DIM
) (
  input logic                    clk,
  input logic                    rst,
  input data_t [EMBED_DIM-1:0]   out_data,
  input logic                    out_valid,
  input logic                    out_ready,
  input logic                    query_ready,
  input logic                    key_valid,
  input logic                    key_ready,
  input logic                    key_release,
  input logic                    value_ready
);

  int failures = 0;
  int keys_held;

  // Key rows taken since the key buffer was last emptied
  always @(posedge clk) begin
    if (rst || key_release) begin
      keys_held <= 0;
    end else if (key_valid && key_ready) begin
      keys_held <= keys_held + 1;
    end
  end

  stalled_out_stable: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
      failures++;
      $error("out stream changed while stalled");
    end

  query_waits_for_keys: assert property (@(posedge clk) disable iff (rst)
      query_ready |-> keys_held == SEQ_LEN)
    else begin
      failures++;
      $error("query_ready high before all key rows were taken");
    end

  // State right after a reset cycle
  reset_state: assert property (@(posedge clk)
      rst |=> !out_valid && !query_ready && key_ready && value_ready)
    else begin
      failures++;
      $error("wrong handshake state after reset");
    end

endmodule

bind fixed_self_attention_head attention_head_checker #(
  .SEQ_LEN(SEQ_LEN),
  .EMBED_DIM(EMBED_DIM)
) checker_i (
  .clk(clk), .rst(rst),
  .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
  .query_ready(query_ready), .key_valid(key_valid),
  .key_ready(key_ready), .key_release(key_release),
  .value_ready(value_ready)
);

`default_nettype wire

//--- testbench/attention_head_monitor.sv
`default_nettype none

module attention_head_monitor import attention_pkg::*; #(
  parameter int SEQ_LEN = DEFAULT_SEQ_LEN,
  parameter int EMBED_DIM = DEFAULT_EMBED_DIM,
  parameter int TILES = 5
) (
  input  logic                    clk,
  input  logic                    rst,
  input  data_t [EMBED_DIM-1:0]   out_data,
  input  logic                    out_valid,
  input  logic                    out_ready,
  output int                      out_count,
  output int                      error_count
);

  localparam int ROWS = TILES * SEQ_LEN;
  localparam int ROW_W = EMBED_DIM * DATA_WIDTH;

  logic [ROW_W-1:0] stim [ROWS * 4];
  logic [ROW_W-1:0] expected;
  int count = 0;
  int errors = 0;

  assign out_count = count;
  assign error_count = errors;

  initial begin
    $readmemh("testbench/attention_testdata.txt", stim);
  end

  // Expected row sits in the fourth column of each token line
  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (count >= ROWS) begin
        errors++;
        $display("Extra output row %h after all %0d expected rows", out_data, ROWS);
      end else begin
        expected = stim[count * 4 + 3];
        if (out_data !== expected) begin
          errors++;
          $display("FAILED tile %0d row %0d: expected %h, actual %h",
                   count / SEQ_LEN, count % SEQ_LEN, expected, out_data);
        end
      end
      count++;
    end
  end

endmodule

`default_nettype wire

//--- testbench/attention_head_tb.sv
`default_nettype none

module attention_head_tb import attention_pkg::*; ();

  localparam int SEQ_LEN = DEFAULT_SEQ_LEN;
  localparam int EMBED_DIM = DEFAULT_EMBED_DIM;
  localparam int TILES = 5;
  localparam int ROW_W = EMBED_DIM * DATA_WIDTH;
  localparam int WORDS = TILES * SEQ_LEN * 4;
  localparam int WATCHDOG_CYCLES = TILES * SEQ_LEN * 40 + 200;
  // Keys of this tile all go in before any of its values
  localparam int ORDER_TILE = 3;

  logic clk;
  logic rst;
  data_t [EMBED_DIM-1:0] key_data;
  logic key_valid;
  logic key_ready;
  data_t [EMBED_DIM-1:0] value_data;
  logic value_valid;
  logic value_ready;
  data_t [EMBED_DIM-1:0] query_data;
  logic query_valid;
  logic query_ready;
  data_t [EMBED_DIM-1:0] out_data;
  logic out_valid;
  logic out_ready;

  logic [ROW_W-1:0] stim [WORDS];
  int seed;
  int out_count;
  int monitor_errors;
  int tb_errors;
  int keys_sent_tile;
  logic back_pressure;

  fixed_self_attention_head #(.SEQ_LEN(SEQ_LEN), .EMBED_DIM(EMBED_DIM)) dut_i (
    .clk(clk), .rst(rst),
    .key_data(key_data), .key_valid(key_valid), .key_ready(key_ready),
    .value_data(value_data), .value_valid(value_valid), .value_ready(value_ready),
    .query_data(query_data), .query_valid(query_valid), .query_ready(query_ready),
    .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
  );

  attention_head_monitor #(.SEQ_LEN(SEQ_LEN), .EMBED_DIM(EMBED_DIM), .TILES(TILES)) monitor_i (
    .clk(clk), .rst(rst),
    .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
    .out_count(out_count), .error_count(monitor_errors)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    #1;
    out_ready = back_pressure ? (($random(seed) & 3) != 0) : 1'b1;
  end

  function automatic int word_index(input int tile, input int token, input int col);
    word_index = (tile * SEQ_LEN + token) * 4 + col;
  endfunction

  task automatic idle_gap();
    int gap;
    gap = $unsigned($random(seed)) % 3;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_key(input logic [ROW_W-1:0] row);
    idle_gap();
    key_data = row;
    key_valid = 1'b1;
    @(posedge clk);
    while (!key_ready) @(posedge clk);
    #1;
    key_valid = 1'b0;
  endtask

  task automatic send_value(input logic [ROW_W-1:0] row);
    idle_gap();
    value_data = row;
    value_valid = 1'b1;
    @(posedge clk);
    while (!value_ready) @(posedge clk);
    #1;
    value_valid = 1'b0;
  endtask

  task automatic send_query(input logic [ROW_W-1:0] row);
    idle_gap();
    query_data = row;
    query_valid = 1'b1;
    @(posedge clk);
    while (!query_ready) @(posedge clk);
    #1;
    query_valid = 1'b0;
  endtask

  task automatic stream_keys(input int first, input int last);
    for (int t = first; t <= last; t++) begin
      for (int i = 0; i < SEQ_LEN; i++) begin
        send_key(stim[word_index(t, i, 0)]);
      end
      keys_sent_tile = t;
    end
  endtask

  task automatic stream_values(input int first, input int last);
    for (int t = first; t <= last; t++) begin
      if (t == ORDER_TILE) begin
        wait (keys_sent_tile >= t);
        repeat (20) @(posedge clk);
        #1;
      end
      for (int i = 0; i < SEQ_LEN; i++) begin
        send_value(stim[word_index(t, i, 1)]);
      end
    end
  endtask

  task automatic stream_queries(input int first, input int last);
    for (int t = first; t <= last; t++) begin
      for (int i = 0; i < SEQ_LEN; i++) begin
        send_query(stim[word_index(t, i, 2)]);
      end
    end
  endtask

  task automatic run_tiles(input int first, input int last);
    fork
      stream_keys(first, last);
      stream_values(first, last);
      stream_queries(first, last);
    join
    wait (out_count >= (last + 1) * SEQ_LEN);
    #1;
  endtask

  function automatic int total_errors();
    total_errors = monitor_errors + tb_errors + dut_i.checker_i.failures;
  endfunction

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: only %0d of %0d output rows arrived", out_count, TILES * SEQ_LEN);
    $display("Errors: %0d", total_errors() + 1);
    $display("Verification failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    key_data = '0;
    key_valid = 1'b0;
    value_data = '0;
    value_valid = 1'b0;
    query_data = '0;
    query_valid = 1'b0;
    out_ready = 1'b1;
    back_pressure = 1'b0;
    tb_errors = 0;
    keys_sent_tile = -1;
    seed = 32'h938360eb;
    $readmemh("testbench/attention_testdata.txt", stim);
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    run_tiles(0, 1);
    back_pressure = 1'b1;
    run_tiles(2, 3);
    back_pressure = 1'b0;

    // Partial tile, then reset while its query is still in the pipeline
    fork
      stream_keys(0, 0);
      stream_values(0, 0);
      send_query(stim[word_index(0, 0, 2)]);
    join
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (30) begin
      @(posedge clk);
      if (out_valid) begin
        tb_errors++;
        $display("out_valid went high after reset with no new tile sent");
      end
    end
    #1;
    run_tiles(4, 4);
    repeat (20) @(posedge clk);

    $display("Errors: %0d (monitor %0d, testbench %0d, assertions %0d)", total_errors(),
             monitor_errors, tb_errors, dut_i.checker_i.failures);
    if (total_errors() == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/attention_testdata.txt
// One token per line: key value query expected, each word holds elements 3..0
// Five tiles of four tokens
00000010 00000010 00203040 01040810
00001000 00001000 00000000 10101010
00100000 00100000 00081810 08081010
10000000 10000000 90E000F0 00041008
00000010 00F01020 00000000 3C080034
00001000 10101010 00000040 04F20F21
00100000 3008E000 00302000 380EEA0D
10000000 FC000004 7FF8F8F8 FC000004
00000010 80807F7F 00000000 80807F7F
00001000 80807F7F 00000040 80807F7F
00100000 80807F7F 8080807F 80807F7F
10000000 10101010 7F808080 0F0F1111
10101010 00000010 00001010 01041010
00000020 00001000 00000008 08081010
00000000 00100000 30000000 00020210
F0F0F0F0 10000000 000000E0 10040001
00000010 00000010 00100020 04080410
00001000 00001000 7F7F7F7F 10101010
00100000 00100000 00000080 10101000
10000000 10000000 33221100 10080402

//--- verilog/attention_pkg.sv
`default_nettype none

package attention_pkg;

  // Element format, Q3.4
  localparam int DATA_WIDTH = 8;
  localparam int FRAC_BITS = 4;
  localparam int DATA_MAX = 2 ** (DATA_WIDTH - 1) - 1;
  localparam int DATA_MIN = -(2 ** (DATA_WIDTH - 1));

  localparam int SCORE_WIDTH = 20;

  // Weight is 1.0 at 256
  localparam int WEIGHT_FRAC = 8;
  localparam int WEIGHT_WIDTH = 9;
  localparam int MAX_SHIFT = 8;

  localparam int ACC_WIDTH = 28;

  localparam int DEFAULT_SEQ_LEN = 4;
  localparam int DEFAULT_EMBED_DIM = 4;

  typedef logic signed [DATA_WIDTH-1:0] data_t;
  typedef logic signed [SCORE_WIDTH-1:0] score_t;
  typedef logic [WEIGHT_WIDTH-1:0] weight_t;
  typedef logic signed [ACC_WIDTH-1:0] acc_t;

  // Drop the weight fraction with round half up, then clamp to the element range
  function automatic data_t round_saturate(input acc_t value);
    acc_t shifted;
    shifted = (value + (acc_t'(1) <<< (WEIGHT_FRAC - 1))) >>> WEIGHT_FRAC;
    if (shifted > DATA_MAX) begin
      round_saturate = data_t'(DATA_MAX);
    end else if (shifted < DATA_MIN) begin
      round_saturate = data_t'(DATA_MIN);
    end else begin
      round_saturate = data_t'(shifted);
    end
  endfunction

endpackage

`default_nettype wire

//--- verilog/fixed_self_attention_head.sv
`default_nettype none

module fixed_self_attention_head import attention_pkg::*; #(
  parameter int SEQ_LEN = DEFAULT_SEQ_LEN,
  parameter int EMBED_DIM = DEFAULT_EMBED_DIM
) (
  input  logic                    clk,
  input  logic                    rst,
  input  data_t [EMBED_DIM-1:0]   key_data,
  input  logic                    key_valid,
  output logic                    key_ready,
  input  data_t [EMBED_DIM-1:0]   value_data,
  input  logic                    value_valid,
  output logic                    value_ready,
  input  data_t [EMBED_DIM-1:0]   query_data,
  input  logic                    query_valid,
  output logic                    query_ready,
  output data_t [EMBED_DIM-1:0]   out_data,
  output logic                    out_valid,
  input  logic                    out_ready
);

  typedef data_t [EMBED_DIM-1:0] data_row_t;

  logic key_full;
  logic [$clog2(SEQ_LEN)-1:0] key_index;
  data_row_t key_row;
  logic key_release;
  logic value_full;
  logic [$clog2(SEQ_LEN)-1:0] value_index;
  data_row_t value_row;
  logic value_release;
  score_t [SEQ_LEN-1:0] score_data;
  logic score_valid;
  logic score_ready;
  weight_t [SEQ_LEN-1:0] weight_data;
  logic weight_valid;
  logic weight_ready;
  acc_t [EMBED_DIM-1:0] acc_data;
  logic acc_valid;
  logic acc_ready;

  // Keys stay as rows, the read index walks them as columns of K^T
  row_matrix_buffer #(.SEQ_LEN(SEQ_LEN), .ROW_T(data_row_t)) key_buffer_i (
    .clk(clk), .rst(rst),
    .in_data(key_data), .in_valid(key_valid), .in_ready(key_ready),
    .full(key_full), .rd_index(key_index), .rd_data(key_row),
    .release_pulse(key_release)
  );

  row_matrix_buffer #(.SEQ_LEN(SEQ_LEN), .ROW_T(data_row_t)) value_buffer_i (
    .clk(clk), .rst(rst),
    .in_data(value_data), .in_valid(value_valid), .in_ready(value_ready),
    .full(value_full), .rd_index(value_index), .rd_data(value_row),
    .release_pulse(value_release)
  );

  query_key_scores #(.SEQ_LEN(SEQ_LEN), .EMBED_DIM(EMBED_DIM)) query_key_scores_i (
    .clk(clk), .rst(rst),
    .query_data(query_data), .query_valid(query_valid), .query_ready(query_ready),
    .key_full(key_full), .key_index(key_index), .key_row(key_row),
    .key_release(key_release),
    .score_data(score_data), .score_valid(score_valid), .score_ready(score_ready)
  );

  shift_softermax #(.SEQ_LEN(SEQ_LEN)) shift_softermax_i (
    .clk(clk), .rst(rst),
    .score_data(score_data), .score_valid(score_valid), .score_ready(score_ready),
    .weight_data(weight_data), .weight_valid(weight_valid), .weight_ready(weight_ready)
  );

  weighted_value_sum #(.SEQ_LEN(SEQ_LEN), .EMBED_DIM(EMBED_DIM)) weighted_value_sum_i (
    .clk(clk), .rst(rst),
    .weight_data(weight_data), .weight_valid(weight_valid), .weight_ready(weight_ready),
    .value_full(value_full), .value_index(value_index), .value_row(value_row),
    .value_release(value_release),
    .acc_data(acc_data), .acc_valid(acc_valid), .acc_ready(acc_ready)
  );

  output_round_slice #(.EMBED_DIM(EMBED_DIM)) output_round_slice_i (
    .clk(clk), .rst(rst),
    .acc_data(acc_data), .acc_valid(acc_valid), .acc_ready(acc_ready),
    .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
  );

endmodule

`default_nettype wire

//--- verilog/output_round_slice.sv
`default_nettype none

module output_round_slice import attention_pkg::*; #(
  parameter int EMBED_DIM = DEFAULT_EMBED_DIM
) (
  input  logic                    clk,
  input  logic                    rst,
  input  acc_t [EMBED_DIM-1:0]    acc_data,
  input  logic                    acc_valid,
  output logic                    acc_ready,
  output data_t [EMBED_DIM-1:0]   out_data,
  output logic                    out_valid,
  input  logic                    out_ready
);

  logic [1:0] count;
  logic push;
  logic pop;
  data_t [EMBED_DIM-1:0] rounded;
  data_t [EMBED_DIM-1:0] slot0;
  data_t [EMBED_DIM-1:0] slot1;

  // Ready depends only on the held count
  assign acc_ready = (count != 2'd2);
  assign out_valid = (count != 2'd0);
  assign out_data = slot0;
  assign push = acc_valid && acc_ready;
  assign pop = out_valid && out_ready;

  always_comb begin
    for (int i = 0; i < EMBED_DIM; i++) begin
      rounded[i] = round_saturate(acc_data[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= 2'd0;
    end else if (push && !pop) begin
      count <= count + 2'd1;
    end else if (pop && !push) begin
      count <= count - 2'd1;
    end
  end

  // slot0 is always the head
  always_ff @(posedge clk) begin
    if (pop) begin
      if (count == 2'd2) begin
        slot0 <= slot1;
      end else if (push) begin
        slot0 <= rounded;
      end
    end else if (push) begin
      if (count == 2'd0) begin
        slot0 <= rounded;
      end else begin
        slot1 <= rounded;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/query_key_scores.sv
`default_nettype none

module query_key_scores import attention_pkg::*; #(
  parameter int SEQ_LEN = DEFAULT_SEQ_LEN,
  parameter int EMBED_DIM = DEFAULT_EMBED_DIM
) (
  input  logic                          clk,
  input  logic                          rst,
  input  data_t [EMBED_DIM-1:0]         query_data,
  input  logic                          query_valid,
  output logic                          query_ready,
  input  logic                          key_full,
  output logic [$clog2(SEQ_LEN)-1:0]    key_index,
  input  data_t [EMBED_DIM-1:0]         key_row,
  output logic                          key_release,
  output score_t [SEQ_LEN-1:0]          score_data,
  output logic                          score_valid,
  input  logic                          score_ready
);

  localparam int INDEX_WIDTH = $clog2(SEQ_LEN);
  localparam int STEP_WIDTH = $clog2(SEQ_LEN + 1);
  localparam int DOT_WIDTH = SCORE_WIDTH + FRAC_BITS;

  typedef enum logic [1:0] {IDLE, RUN, DONE} state_t;

  state_t state;
  logic [STEP_WIDTH-1:0] step;
  logic [INDEX_WIDTH-1:0] query_count;
  logic query_accept;
  logic last_step;
  data_t [EMBED_DIM-1:0] query_q;
  logic signed [DOT_WIDTH-1:0] dot_sum;
  logic signed [DOT_WIDTH-1:0] dot_q;
  score_t [SEQ_LEN-1:0] score_q;

  assign query_ready = (state == IDLE) && key_full;
  assign query_accept = query_valid && query_ready;
  assign key_index = step[INDEX_WIDTH-1:0];
  assign last_step = (state == RUN) && (step == STEP_WIDTH'(SEQ_LEN));

  // Keys are done with once the last query of the tile has been through them
  assign key_release = last_step && (query_count == INDEX_WIDTH'(SEQ_LEN - 1));

  assign score_data = score_q;
  assign score_valid = (state == DONE);

  always_comb begin
    dot_sum = '0;
    for (int i = 0; i < EMBED_DIM; i++) begin
      dot_sum = dot_sum + query_q[i] * key_row[i];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      step <= '0;
      query_count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (query_accept) begin
            state <= RUN;
            step <= '0;
          end
        end
        RUN: begin
          step <= step + 1'b1;
          if (last_step) begin
            state <= DONE;
            query_count <= key_release ? '0 : query_count + 1'b1;
          end
        end
        DONE: begin
          if (score_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Dot product is registered, then scaled into the score row one step later
  always_ff @(posedge clk) begin
    if (query_accept) begin
      query_q <= query_data;
    end
    if (state == RUN) begin
      dot_q <= dot_sum;
      if (step != '0) begin
        score_q[step - 1'b1] <= score_t'(dot_q >>> FRAC_BITS);
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/row_matrix_buffer.sv
`default_nettype none

module row_matrix_buffer #(
  parameter int SEQ_LEN = 4,
  parameter type ROW_T = logic [31:0]
) (
  input  logic                       clk,
  input  logic                       rst,
  input  ROW_T                       in_data,
  input  logic                       in_valid,
  output logic                       in_ready,
  output logic                       full,
  input  logic [$clog2(SEQ_LEN)-1:0] rd_index,
  output ROW_T                       rd_data,
  input  logic                       release_pulse
);

  localparam int INDEX_WIDTH = $clog2(SEQ_LEN);

  ROW_T rows [SEQ_LEN];
  logic [INDEX_WIDTH-1:0] wr_index;
  logic write;

  assign in_ready = !full;
  assign write = in_valid && in_ready;

  // Any stored row can be read at any time
  assign rd_data = rows[rd_index];

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
      wr_index <= '0;
    end else if (release_pulse) begin
      full <= 1'b0;
      wr_index <= '0;
    end else if (write) begin
      if (wr_index == INDEX_WIDTH'(SEQ_LEN - 1)) begin
        wr_index <= '0;
        full <= 1'b1;
      end else begin
        wr_index <= wr_index + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      rows[wr_index] <= in_data;
    end
  end

endmodule

`default_nettype wire

//--- verilog/shift_softermax.sv
`default_nettype none

module shift_softermax import attention_pkg::*; #(
  parameter int SEQ_LEN = DEFAULT_SEQ_LEN
) (
  input  logic                    clk,
  input  logic                    rst,
  input  score_t [SEQ_LEN-1:0]    score_data,
  input  logic                    score_valid,
  output logic                    score_ready,
  output weight_t [SEQ_LEN-1:0]   weight_data,
  output logic                    weight_valid,
  input  logic                    weight_ready
);

  localparam weight_t WEIGHT_ONE = weight_t'(1 << WEIGHT_FRAC);

  score_t row_max;
  logic [SEQ_LEN-1:0][SCORE_WIDTH:0] distance;
  weight_t [SEQ_LEN-1:0] weight_next;
  weight_t [SEQ_LEN-1:0] weight_q;
  logic score_accept;

  assign score_ready = !weight_valid || weight_ready;
  assign score_accept = score_valid && score_ready;
  assign weight_data = weight_q;

  always_comb begin
    row_max = score_data[0];
    for (int i = 1; i < SEQ_LEN; i++) begin
      if (score_data[i] > row_max) begin
        row_max = score_data[i];
      end
    end
  end

  // One extra bit keeps the difference positive over the full score range
  always_comb begin
    for (int i = 0; i < SEQ_LEN; i++) begin
      distance[i] = ((SCORE_WIDTH + 1)'(row_max) - (SCORE_WIDTH + 1)'(score_data[i]))
                    >> FRAC_BITS;
      if (distance[i] > MAX_SHIFT) begin
        distance[i] = (SCORE_WIDTH + 1)'(MAX_SHIFT);
      end
      weight_next[i] = WEIGHT_ONE >> distance[i];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      weight_valid <= 1'b0;
    end else if (score_accept) begin
      weight_valid <= 1'b1;
    end else if (weight_ready) begin
      weight_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (score_accept) begin
      weight_q <= weight_next;
    end
  end

endmodule

`default_nettype wire

//--- verilog/weighted_value_sum.sv
`default_nettype none

module weighted_value_sum import attention_pkg::*; #(
  parameter int SEQ_LEN = DEFAULT_SEQ_LEN,
  parameter int EMBED_DIM = DEFAULT_EMBED_DIM
) (
  input  logic                          clk,
  input  logic                          rst,
  input  weight_t [SEQ_LEN-1:0]         weight_data,
  input  logic                          weight_valid,
  output logic                          weight_ready,
  input  logic                          value_full,
  output logic [$clog2(SEQ_LEN)-1:0]    value_index,
  input  data_t [EMBED_DIM-1:0]         value_row,
  output logic                          value_release,
  output acc_t [EMBED_DIM-1:0]          acc_data,
  output logic                          acc_valid,
  input  logic                          acc_ready
);

  localparam int INDEX_WIDTH = $clog2(SEQ_LEN);
  localparam int STEP_WIDTH = $clog2(SEQ_LEN + 1);

  typedef enum logic [1:0] {IDLE, RUN, DONE} state_t;

  state_t state;
  logic [STEP_WIDTH-1:0] step;
  logic [INDEX_WIDTH-1:0] row_count;
  logic weight_accept;
  logic last_step;
  weight_t [SEQ_LEN-1:0] weight_q;
  acc_t [EMBED_DIM-1:0] prod_q;
  acc_t [EMBED_DIM-1:0] acc_q;

  // Nothing starts until the whole value matrix is in
  assign weight_ready = (state == IDLE) && value_full;
  assign weight_accept = weight_valid && weight_ready;
  assign value_index = step[INDEX_WIDTH-1:0];
  assign last_step = (state == RUN) && (step == STEP_WIDTH'(SEQ_LEN));
  assign value_release = last_step && (row_count == INDEX_WIDTH'(SEQ_LEN - 1));

  assign acc_data = acc_q;
  assign acc_valid = (state == DONE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      step <= '0;
      row_count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (weight_accept) begin
            state <= RUN;
            step <= '0;
          end
        end
        RUN: begin
          step <= step + 1'b1;
          if (last_step) begin
            state <= DONE;
            row_count <= value_release ? '0 : row_count + 1'b1;
          end
        end
        DONE: begin
          if (acc_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Products are registered per column and summed on the following step
  always_ff @(posedge clk) begin
    if (weight_accept) begin
      weight_q <= weight_data;
      acc_q <= '0;
    end
    if (state == RUN) begin
      for (int j = 0; j < EMBED_DIM; j++) begin
        prod_q[j] <= $signed({1'b0, weight_q[value_index]}) * value_row[j];
        if (step != '0) begin
          acc_q[j] <= acc_q[j] + prod_q[j];
        end
      end
    end
  end

endmodule

`default_nettype wire
